//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = f8_tb
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "all tests passed"

clean:
	rm -rf obj_dir

//--- bench/f8_core_props.sv
module f8_core_props
	import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input word_t iread_addr,
	input fetch_t iread_data,
	input logic [1:0] dwrite_en,
	input logic trap
);

	int failures = 0;
	logic is_jump;

	assign is_jump = iread_data[7:0] inside {JR, JRZ, JRNZ, JRC, JRNC};

	reset_quiet: assert property (@(posedge clk) reset |-> (dwrite_en == 2'b00 && !trap))
	else
	begin
		failures++;
		$error("memory write or trap active during reset");
	end

	trap_holds_pc: assert property (@(posedge clk) disable iff (reset)
		trap |=> $stable(iread_addr))
	else
	begin
		failures++;
		$error("pc moved after trap");
	end

	// straight-line code steps by the instruction length
	pc_advance: assert property (@(posedge clk) disable iff (reset)
		(!trap && !is_jump) |=> ((iread_addr - $past(iread_addr)) inside {[16'd1:16'd3]}))
	else
	begin
		failures++;
		$error("pc did not advance by one to three bytes");
	end

endmodule

bind f8_core f8_core_props u_props (.*);

//--- bench/f8_tb.sv
module f8_tb
	import f8_pkg::*;
();

	typedef struct packed {
		word_t addr;
		word_t data;
		logic [1:0] en;
	} store_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	word_t iread_addr;
	fetch_t iread_data;
	word_t dread_addr;
	word_t dread_data;
	word_t dwrite_addr;
	word_t dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	byte_t mem [65536];
	logic [31:0] lfsr_state = 32'h8ebba35e;
	word_t apc = RESET_PC;
	int n_inst = 0;
	int value_errors = 0;
	int other_errors = 0;
	store_t exp_q [$];
	string exp_name [$];

	// reference model of XL and the flags
	byte_t m_xl;
	flags_t m_f = FLAGS_NONE;
	opcode_t alu_ops [8] = '{ADD_XL_IMM, SUB_XL_IMM, AND_XL_IMM, OR_XL_IMM,
		XOR_XL_IMM, CP_XL_IMM, INC_XL, DEC_XL};

	f8_core u_dut (.*);

	always #10 clk = ~clk;

	assign iread_data = {mem[iread_addr + 16'd2], mem[iread_addr + 16'd1], mem[iread_addr]};
	assign dread_data = {mem[dread_addr + 16'd1], mem[dread_addr]};

	always @(posedge clk)
	begin
		if (dwrite_en[0])
			mem[dwrite_addr] = dwrite_data[7:0];
		if (dwrite_en[1])
			mem[dwrite_addr + 16'd1] = dwrite_data[15:8];
	end

	// taps 32, 22, 2, 1
	function logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[14:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// mixes both address bytes
	function byte_t fill(word_t a);
		return a[7:0] ^ a[15:8] ^ 8'h3c;
	endfunction

	function int inst_len(opcode_t op);
		if (op == NOP || op == TRAP || op == INC_XL || op == DEC_XL)
			return 1;
		if (op[7:4] == 4'h1 || op[7:4] == 4'h4 || op == LD_XL_IMM)
			return 2;
		return 3;
	endfunction

	task emit(opcode_t op, word_t operand);
		int len;
		len = inst_len(op);
		mem[apc] = op;
		if (len > 1)
			mem[apc + 16'd1] = operand[7:0];
		if (len > 2)
			mem[apc + 16'd2] = operand[15:8];
		apc = apc + word_t'(len);
		n_inst++;
	endtask

	task expect_store(string name, word_t addr, word_t data, logic [1:0] en);
		exp_q.push_back('{addr: addr, data: data, en: en});
		exp_name.push_back(name);
	endtask

	task store_xl(string name, word_t addr);
		emit(LD_DIR_XL, addr);
		expect_store(name, addr, {8'h00, m_xl}, 2'b01);
	endtask

	// sub, compare and dec add the complement plus one
	task model_alu8(opcode_t op, byte_t b);
		logic [8:0] s;
		case (op)
			ADD_XL_IMM: s = {1'b0, m_xl} + {1'b0, b};
			SUB_XL_IMM, CP_XL_IMM: s = {1'b0, m_xl} + {1'b0, ~b} + 9'd1;
			INC_XL: s = {1'b0, m_xl} + 9'd1;
			DEC_XL: s = {1'b0, m_xl} + {1'b0, ~8'h01} + 9'd1;
			AND_XL_IMM: s = {m_f.c, m_xl & b};
			OR_XL_IMM: s = {m_f.c, m_xl | b};
			default: s = {m_f.c, m_xl ^ b};
		endcase
		m_f = '{c: s[8], z: s[7:0] == 8'h00, n: s[7]};
		if (op != CP_XL_IMM)
			m_xl = s[7:0];
	endtask

	// not-taken block is 7 bytes, taken block 5
	task branch_trial(opcode_t jop, byte_t a, byte_t b, int k);
		logic taken;
		emit(LD_XL_IMM, {8'h00, a});
		m_xl = a;
		emit(CP_XL_IMM, {8'h00, b});
		model_alu8(CP_XL_IMM, b);
		case (jop)
			JRZ: taken = m_f.z;
			JRNZ: taken = !m_f.z;
			JRC: taken = m_f.c;
			JRNC: taken = !m_f.c;
			default: taken = 1'b1;
		endcase
		emit(jop, 16'd9);
		emit(LD_XL_IMM, {8'h00, 8'ha0 | byte_t'(k)});
		emit(LD_DIR_XL, 16'h9000 + word_t'(k));
		emit(JR, 16'd7);
		emit(LD_XL_IMM, {8'h00, 8'hb0 | byte_t'(k)});
		emit(LD_DIR_XL, 16'h9000 + word_t'(k));
		m_xl = taken ? (8'hb0 | byte_t'(k)) : (8'ha0 | byte_t'(k));
		expect_store($sformatf("branch %s", jop.name()), 16'h9000 + word_t'(k),
			{8'h00, m_xl}, 2'b01);
	endtask

	task check_store();
		store_t e;
		string name;
		word_t got;
		if (exp_q.size() == 0)
		begin
			other_errors++;
			$display("unexpected memory write at address %h", dwrite_addr);
		end
		else
		begin
			e = exp_q.pop_front();
			name = exp_name.pop_front();
			got = dwrite_en[1] ? dwrite_data : {8'h00, dwrite_data[7:0]};
			assert (got == e.data && dwrite_addr == e.addr && dwrite_en == e.en)
			else
			begin
				value_errors++;
				$display("Error %s: expected addr %h data %h en %b, actual addr %h data %h en %b",
					name, e.addr, e.data, e.en, dwrite_addr, got, dwrite_en);
			end
		end
	endtask

	always @(negedge clk)
	begin
		if (!reset && dwrite_en != 2'b00)
			check_store();
	end

	initial
	begin
		#1;
		repeat (40 * n_inst + 200) @(posedge clk);
		$display("timeout: the core never reached its trap");
		$display("tests failed");
		$finish;
	end

	initial
	begin
		byte_t b;
		word_t w;
		word_t v;
		logic [16:0] s16;
		opcode_t op;
		byte_t first_op;
		for (int i = 0; i < 65536; i++)
			mem[i] = fill(word_t'(i));

		b = byte_t'(rand_bits(8));
		emit(LD_XL_IMM, {8'h00, b});
		m_xl = b;
		for (int i = 0; i < 24; i++)
		begin
			op = alu_ops[3'(rand_bits(3))];
			b = byte_t'(rand_bits(8));
			emit(op, {8'h00, b});
			model_alu8(op, b);
			store_xl($sformatf("alu %s", op.name()), 16'h8000 + word_t'(i));
		end

		for (int i = 0; i < 3; i++)
		begin
			w = rand_bits(16);
			v = rand_bits(16);
			emit(LDW_Y_IMM, w);
			emit(LDW_DIR_Y, 16'ha000 + word_t'(4 * i));
			expect_store("ldw y", 16'ha000 + word_t'(4 * i), w, 2'b11);
			emit(ADDW_Y_IMM, v);
			s16 = {1'b0, w} + {1'b0, v};
			m_f = '{c: s16[16], z: s16[15:0] == 16'h0000, n: s16[15]};
			emit(LDW_DIR_Y, 16'ha002 + word_t'(4 * i));
			expect_store("addw y", 16'ha002 + word_t'(4 * i), s16[15:0], 2'b11);
		end

		for (int i = 0; i < 4; i++)
		begin
			w = 16'h6000 | rand_bits(12);
			emit(LD_XL_DIR, w);
			m_xl = fill(w);
			store_xl("ld xl dir", 16'hb000 + word_t'(i));
		end

		// equal sets z and c, 3 - 9 clears both
		branch_trial(JRZ, 8'h05, 8'h05, 0);
		branch_trial(JRZ, 8'h03, 8'h09, 1);
		branch_trial(JRNZ, 8'h05, 8'h05, 2);
		branch_trial(JRNZ, 8'h03, 8'h09, 3);
		branch_trial(JRC, 8'h05, 8'h05, 4);
		branch_trial(JRC, 8'h03, 8'h09, 5);
		branch_trial(JRNC, 8'h05, 8'h05, 6);
		branch_trial(JRNC, 8'h03, 8'h09, 7);
		branch_trial(JR, 8'h03, 8'h09, 8);

		emit(LD_XL_IMM, 16'h0000);
		m_xl = 8'h00;
		emit(INC_XL, 16'h0000);
		emit(CP_XL_IMM, 16'h0005);
		// back to the INC three bytes earlier
		emit(JRNZ, 16'h00fd);
		repeat (5)
		begin
			model_alu8(INC_XL, 8'h00);
			model_alu8(CP_XL_IMM, 8'h05);
		end
		store_xl("jr loop", 16'h9100);
		emit(TRAP, 16'h0000);

		// core sees a trap and then a store at its reset address while reset is high
		first_op = mem[RESET_PC];
		mem[RESET_PC] = TRAP;
		repeat (5) @(posedge clk);
		#1;
		mem[RESET_PC] = LD_DIR_XL;
		repeat (5) @(posedge clk);
		#1;
		mem[RESET_PC] = first_op;
		reset = 1'b0;
		@(negedge clk);
		assert (iread_addr == RESET_PC && trap == 1'b0 && dwrite_en == 2'b00)
		else
		begin
			other_errors++;
			$display("wrong state after reset: pc %h trap %b dwrite_en %b",
				iread_addr, trap, dwrite_en);
		end

		wait (trap === 1'b1);
		repeat (4)
		begin
			@(negedge clk);
			assert (trap === 1'b1)
			else
			begin
				other_errors++;
				$display("trap dropped after it was raised");
			end
		end
		if (exp_q.size() != 0)
		begin
			other_errors++;
			$display("%0d expected stores never happened", exp_q.size());
		end

		$display("value errors %0d, other errors %0d, assertion failures %0d",
			value_errors, other_errors, u_dut.u_props.failures);
		if (value_errors == 0 && other_errors == 0 && u_dut.u_props.failures == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- compile.f
hw/f8_pkg.sv
hw/f8_decode.sv
hw/f8_execute.sv
hw/f8_writeback.sv
hw/f8_fetch.sv
hw/f8_core.sv
bench/f8_core_props.sv
bench/f8_tb.sv

//--- hw/f8_core.sv
module f8_core
	import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	output word_t iread_addr,
	input fetch_t iread_data,
	output word_t dread_addr,
	input word_t dread_data,
	output word_t dwrite_addr,
	output word_t dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);

	ctrl_t ctrl;
	alu_out_t result;
	word_t x;
	word_t y;
	flags_t flags;
	word_t pc;
	word_t abs_addr;

	// bytes 1 and 2, little-endian
	assign abs_addr = iread_data[23:8];

	assign iread_addr = pc;
	assign dread_addr = abs_addr;
	assign dwrite_addr = abs_addr;
	assign dwrite_data = result.result;
	assign dwrite_en = reset ? 2'b00 : ctrl.mem_we;
	assign trap = !reset && ctrl.trap;

	f8_fetch u_fetch (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.offset(iread_data[15:8]),
		.flags(flags),
		.pc(pc)
	);

	f8_decode u_decode (
		.inst(iread_data),
		.ctrl(ctrl)
	);

	f8_execute u_execute (
		.ctrl(ctrl),
		.inst(iread_data),
		.x(x),
		.y(y),
		.dread_data(dread_data),
		.flags(flags),
		.result(result)
	);

	// z has no reader among the kept instructions
	f8_writeback u_writeback (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.result(result),
		.x(x),
		.y(y),
		.z(),
		.flags(flags)
	);

endmodule

//--- hw/f8_decode.sv
module f8_decode
	import f8_pkg::*;
(
	input fetch_t inst,
	output ctrl_t ctrl
);

	opcode_t op;

	assign op = opcode_t'(inst[7:0]);

	always_comb
	begin
		// defaults describe a NOP
		ctrl = '0;
		ctrl.alu_op = ALU_PASS;
		ctrl.src = SRC_ACC;
		ctrl.reg_dst = REG_X;
		ctrl.flag_mask = FLAGS_NONE;
		ctrl.len = len_t'(1);
		ctrl.branch = BR_NONE;

		case (op)
			TRAP:
				ctrl.trap = 1'b1;
			ADD_XL_IMM, SUB_XL_IMM, CP_XL_IMM:
			begin
				ctrl.alu_op = (op == ADD_XL_IMM) ? ALU_ADD : ALU_SUB;
				ctrl.src = SRC_IMM8;
				// compare only drops the write to XL
				ctrl.reg_we = (op == CP_XL_IMM) ? 2'b00 : 2'b01;
				ctrl.flag_mask = FLAGS_CZN;
				ctrl.len = len_t'(2);
			end
			AND_XL_IMM, OR_XL_IMM, XOR_XL_IMM:
			begin
				if (op == AND_XL_IMM)
					ctrl.alu_op = ALU_AND;
				else if (op == OR_XL_IMM)
					ctrl.alu_op = ALU_OR;
				else
					ctrl.alu_op = ALU_XOR;
				ctrl.src = SRC_IMM8;
				ctrl.reg_we = 2'b01;
				ctrl.flag_mask = FLAGS_ZN;
				ctrl.len = len_t'(2);
			end
			INC_XL, DEC_XL:
			begin
				ctrl.alu_op = (op == INC_XL) ? ALU_INC : ALU_DEC;
				ctrl.reg_we = 2'b01;
				ctrl.flag_mask = FLAGS_CZN;
			end
			LD_XL_IMM:
			begin
				ctrl.src = SRC_IMM8;
				ctrl.reg_we = 2'b01;
				ctrl.len = len_t'(2);
			end
			LD_XL_DIR:
			begin
				ctrl.src = SRC_MEM8;
				ctrl.reg_we = 2'b01;
				ctrl.len = len_t'(3);
			end
			LD_DIR_XL:
			begin
				ctrl.mem_we = 2'b01;
				ctrl.len = len_t'(3);
			end
			LDW_Y_IMM, ADDW_Y_IMM:
			begin
				ctrl.alu_op = (op == ADDW_Y_IMM) ? ALU_ADDW : ALU_PASSW;
				ctrl.src = SRC_IMM16;
				ctrl.wide = 1'b1;
				ctrl.reg_we = 2'b11;
				ctrl.reg_dst = REG_Y;
				ctrl.flag_mask = (op == ADDW_Y_IMM) ? FLAGS_CZN : FLAGS_NONE;
				ctrl.len = len_t'(3);
			end
			LDW_DIR_Y:
			begin
				ctrl.alu_op = ALU_PASSW;
				ctrl.wide = 1'b1;
				ctrl.mem_we = 2'b11;
				ctrl.len = len_t'(3);
			end
			JR, JRZ, JRNZ, JRC, JRNC:
			begin
				case (op)
					JRZ: ctrl.branch = BR_IF_Z;
					JRNZ: ctrl.branch = BR_IF_NZ;
					JRC: ctrl.branch = BR_IF_C;
					JRNC: ctrl.branch = BR_IF_NC;
					default: ctrl.branch = BR_ALWAYS;
				endcase
				ctrl.len = len_t'(2);
			end
			default:
				ctrl.len = len_t'(1);
		endcase
	end

endmodule

//--- hw/f8_execute.sv
module f8_execute
	import f8_pkg::*;
(
	input ctrl_t ctrl,
	input fetch_t inst,
	input word_t x,
	input word_t y,
	input word_t dread_data,
	input flags_t flags,
	output alu_out_t result
);

	byte_t a8;
	byte_t b8;
	byte_t add_b;
	logic add_cin;
	logic [8:0] sum8;
	word_t a16;
	word_t b16;
	logic [16:0] sum16;
	byte_t res8;

	// operand a is XL for byte ops, Y for word ops
	assign a8 = x[7:0];
	assign a16 = y;

	always_comb
	begin
		case (ctrl.src)
			SRC_IMM8: b8 = inst[15:8];
			SRC_IMM16: b8 = inst[15:8];
			SRC_MEM8: b8 = dread_data[7:0];
			default: b8 = a8;
		endcase

		case (ctrl.src)
			SRC_IMM8: b16 = {8'h00, inst[15:8]};
			SRC_IMM16: b16 = inst[23:8];
			SRC_MEM8: b16 = {8'h00, dread_data[7:0]};
			default: b16 = a16;
		endcase
	end

	// one byte adder; subtraction is a + ~b + 1 so carry set means no borrow
	always_comb
	begin
		case (ctrl.alu_op)
			ALU_SUB: {add_b, add_cin} = {~b8, 1'b1};
			ALU_INC: {add_b, add_cin} = {8'h01, 1'b0};
			ALU_DEC: {add_b, add_cin} = {8'hfe, 1'b1};
			default: {add_b, add_cin} = {b8, 1'b0};
		endcase
	end

	assign sum8 = {1'b0, a8} + {1'b0, add_b} + 9'(add_cin);
	assign sum16 = {1'b0, a16} + {1'b0, b16};

	always_comb
	begin
		case (ctrl.alu_op)
			ALU_AND: res8 = a8 & b8;
			ALU_OR: res8 = a8 | b8;
			ALU_XOR: res8 = a8 ^ b8;
			ALU_PASS: res8 = b8;
			default: res8 = sum8[7:0];
		endcase

		result.flags.c = flags.c;
		case (ctrl.alu_op)
			ALU_ADD, ALU_SUB, ALU_INC, ALU_DEC: result.flags.c = sum8[8];
			ALU_ADDW: result.flags.c = sum16[16];
			default: result.flags.c = flags.c;
		endcase

		if (ctrl.alu_op == ALU_ADDW)
			result.result = sum16[15:0];
		else if (ctrl.alu_op == ALU_PASSW)
			result.result = b16;
		else
			result.result = {8'h00, res8};

		// z and n over the operation width
		if (ctrl.wide)
		begin
			result.flags.z = (result.result == 16'h0000);
			result.flags.n = result.result[15];
		end
		else
		begin
			result.flags.z = (res8 == 8'h00);
			result.flags.n = res8[7];
		end
	end

endmodule

//--- hw/f8_fetch.sv
module f8_fetch
	import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input ctrl_t ctrl,
	input byte_t offset,
	input flags_t flags,
	output word_t pc
);

	logic taken;
	word_t next_pc;

	always_comb
	begin
		case (ctrl.branch)
			BR_ALWAYS: taken = 1'b1;
			BR_IF_Z: taken = flags.z;
			BR_IF_NZ: taken = !flags.z;
			BR_IF_C: taken = flags.c;
			BR_IF_NC: taken = !flags.c;
			default: taken = 1'b0;
		endcase
	end

	// trap parks the core on its own address
	always_comb
	begin
		if (ctrl.trap)
			next_pc = pc;
		else if (taken)
			next_pc = pc + {{8{offset[7]}}, offset};
		else
			next_pc = pc + word_t'(ctrl.len);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= RESET_PC;
		else
			pc <= next_pc;
	end

endmodule

//--- hw/f8_pkg.sv
package f8_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [23:0] fetch_t;

	localparam word_t RESET_PC = 16'h4000;
	localparam int INST_LEN_MAX = 3;

	// instruction length in bytes, 1 to INST_LEN_MAX
	typedef logic [$clog2(INST_LEN_MAX + 1) - 1:0] len_t;

	typedef enum logic [1:0] {
		REG_X,
		REG_Y,
		REG_Z
	} reg_sel_t;

	typedef enum logic [7:0] {
		NOP = 8'h00,
		TRAP = 8'h01,
		ADD_XL_IMM = 8'h10,
		SUB_XL_IMM = 8'h11,
		AND_XL_IMM = 8'h12,
		OR_XL_IMM = 8'h13,
		XOR_XL_IMM = 8'h14,
		CP_XL_IMM = 8'h15,
		INC_XL = 8'h18,
		DEC_XL = 8'h19,
		LD_XL_IMM = 8'h20,
		LD_XL_DIR = 8'h21,
		LD_DIR_XL = 8'h22,
		LDW_Y_IMM = 8'h30,
		ADDW_Y_IMM = 8'h31,
		LDW_DIR_Y = 8'h32,
		JR = 8'h40,
		JRZ = 8'h41,
		JRNZ = 8'h42,
		JRC = 8'h43,
		JRNC = 8'h44
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_DEC,
		ALU_PASS,
		ALU_ADDW,
		ALU_PASSW
	} alu_op_t;

	// second operand; SRC_ACC feeds the accumulator itself, used by stores
	typedef enum logic [1:0] {
		SRC_IMM8,
		SRC_IMM16,
		SRC_MEM8,
		SRC_ACC
	} src_t;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_ALWAYS,
		BR_IF_Z,
		BR_IF_NZ,
		BR_IF_C,
		BR_IF_NC
	} branch_t;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
	} flags_t;

	localparam flags_t FLAGS_NONE = '{c: 1'b0, z: 1'b0, n: 1'b0};
	localparam flags_t FLAGS_ZN = '{c: 1'b0, z: 1'b1, n: 1'b1};
	localparam flags_t FLAGS_CZN = '{c: 1'b1, z: 1'b1, n: 1'b1};

	typedef struct packed {
		alu_op_t alu_op;
		src_t src;
		logic wide;
		logic [1:0] reg_we;
		reg_sel_t reg_dst;
		logic [1:0] mem_we;
		flags_t flag_mask;
		len_t len;
		branch_t branch;
		logic trap;
	} ctrl_t;

	typedef struct packed {
		word_t result;
		flags_t flags;
	} alu_out_t;

endpackage

//--- hw/f8_writeback.sv
module f8_writeback
	import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input ctrl_t ctrl,
	input alu_out_t result,
	output word_t x,
	output word_t y,
	output word_t z,
	output flags_t flags
);

	word_t regs [3];
	flags_t flags_q;
	flags_t next_flags;

	assign x = regs[REG_X];
	assign y = regs[REG_Y];
	assign z = regs[REG_Z];
	assign flags = flags_q;

	// separate low and high byte writes
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (ctrl.reg_we[i])
				regs[ctrl.reg_dst][i * 8 +: 8] <= result.result[i * 8 +: 8];
		end
	end

	// masked flag update
	always_comb
	begin
		next_flags = flags_q;
		if (ctrl.flag_mask.c)
			next_flags.c = result.flags.c;
		if (ctrl.flag_mask.z)
			next_flags.z = result.flags.z;
		if (ctrl.flag_mask.n)
			next_flags.n = result.flags.n;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags_q <= FLAGS_NONE;
		else
			flags_q <= next_flags;
	end

endmodule
